// File: rtl/rip_core.sv
`timescale 1ns/1ps

module rip_core #(
    parameter int ADDR_MASK_BITS = 16
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              run,
    input  rip_pkg::word_t    mem_head,
    output logic              busy,
    output rip_pkg::mem_req_t ext_req,
    input  rip_pkg::mem_rsp_t ext_rsp
);
    import rip_pkg::*;

    core_state_t state;
    word_t       head;
    logic        core_rst_n;
    logic        arb_idle;

    logic        inst_valid;
    dec_inst_t   inst;
    word_t       inst_pc;
    logic        take;
    logic        redirect;
    word_t       redirect_pc;
    logic        halted;

    reg_addr_t   rs1_num;
    reg_addr_t   rs2_num;
    reg_addr_t   rd_num;
    word_t       rs1;
    word_t       rs2;
    word_t       wdata;
    logic        wen;

    mem_req_t    fetch_req;
    mem_rsp_t    fetch_rsp;
    mem_req_t    exec_req;
    mem_rsp_t    exec_rsp;

    assign busy = (state != CORE_IDLE);

    // units stay in reset between runs, so each run starts at pc 0
    assign core_rst_n = rst_n && busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= CORE_IDLE;
        end else begin
            case (state)
                CORE_IDLE: begin
                    if (run) begin
                        state <= CORE_RUNNING;
                    end
                end
                CORE_RUNNING: begin
                    if (halted) begin
                        state <= arb_idle ? CORE_IDLE : CORE_DRAINING;
                    end
                end
                CORE_DRAINING: begin
                    // a prefetch may still be on the bus
                    if (arb_idle) begin
                        state <= CORE_IDLE;
                    end
                end
                default: state <= CORE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == CORE_IDLE && run) begin
            head <= mem_head;
        end
    end

    rip_fetch fetch (
        .clk        (clk),
        .rst_n      (core_rst_n),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .halted     (halted),
        .take       (take),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .req        (fetch_req),
        .rsp        (fetch_rsp)
    );

    rip_execute execute (
        .clk        (clk),
        .rst_n      (core_rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .take       (take),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .halted     (halted),
        .rs1_num    (rs1_num),
        .rs2_num    (rs2_num),
        .rs1        (rs1),
        .rs2        (rs2),
        .wen        (wen),
        .rd_num     (rd_num),
        .wdata      (wdata),
        .req        (exec_req),
        .rsp        (exec_rsp)
    );

    rip_regfile regfile (
        .clk    (clk),
        .rst_n  (core_rst_n),
        .rs1_num(rs1_num),
        .rs2_num(rs2_num),
        .rs1    (rs1),
        .rs2    (rs2),
        .wen    (wen),
        .rd_num (rd_num),
        .wdata  (wdata)
    );

    rip_mem_arbiter #(
        .ADDR_MASK_BITS(ADDR_MASK_BITS)
    ) mem_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .head     (head),
        .fetch_req(fetch_req),
        .fetch_rsp(fetch_rsp),
        .exec_req (exec_req),
        .exec_rsp (exec_rsp),
        .ext_req  (ext_req),
        .ext_rsp  (ext_rsp),
        .idle     (arb_idle)
    );

endmodule

// File: rtl/rip_decode.sv
`timescale 1ns/1ps

module rip_decode (
    input  rip_pkg::word_t     code,
    output rip_pkg::dec_inst_t inst
);
    import rip_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam word_t      EBREAK_ENC = 32'h0010_0073;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode = code[6:0];
    assign funct3 = code[14:12];
    assign funct7 = code[31:25];

    assign imm_i = {{20{code[31]}}, code[31:20]};
    assign imm_s = {{20{code[31]}}, code[31:25], code[11:7]};
    assign imm_b = {{19{code[31]}}, code[31], code[7], code[30:25], code[11:8], 1'b0};
    assign imm_u = {code[31:12], 12'b0};
    assign imm_j = {{11{code[31]}}, code[31], code[19:12], code[20], code[30:21], 1'b0};

    always_comb begin
        inst.op  = OP_NOP;
        inst.rd  = code[11:7];
        inst.rs1 = code[19:15];
        inst.rs2 = code[24:20];
        inst.imm = imm_i;
        case (opcode)
            OPC_OP: begin
                case ({funct7, funct3})
                    10'b0000000_000: inst.op = OP_ADD;
                    10'b0100000_000: inst.op = OP_SUB;
                    10'b0000000_111: inst.op = OP_AND;
                    10'b0000000_110: inst.op = OP_OR;
                    10'b0000000_100: inst.op = OP_XOR;
                    10'b0000000_010: inst.op = OP_SLT;
                    default:         inst.op = OP_NOP;
                endcase
            end
            OPC_OP_IMM: inst.op = (funct3 == 3'b000) ? OP_ADDI : OP_NOP;
            OPC_LUI: begin
                inst.op  = OP_LUI;
                inst.imm = imm_u;
            end
            OPC_LOAD: inst.op = (funct3 == 3'b010) ? OP_LW : OP_NOP;
            OPC_STORE: begin
                inst.op  = (funct3 == 3'b010) ? OP_SW : OP_NOP;
                inst.imm = imm_s;
            end
            OPC_BRANCH: begin
                if (funct3 == 3'b000) begin
                    inst.op = OP_BEQ;
                end else if (funct3 == 3'b001) begin
                    inst.op = OP_BNE;
                end
                inst.imm = imm_b;
            end
            OPC_JAL: begin
                inst.op  = OP_JAL;
                inst.imm = imm_j;
            end
            default: begin
                // only the exact ebreak word ends a run
                if (code == EBREAK_ENC) begin
                    inst.op = OP_EBREAK;
                end
            end
        endcase
    end

endmodule

// File: rtl/rip_execute.sv
`timescale 1ns/1ps

module rip_execute (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               inst_valid,
    input  rip_pkg::dec_inst_t inst,
    input  rip_pkg::word_t     inst_pc,
    output logic               take,
    output logic               redirect,
    output rip_pkg::word_t     redirect_pc,
    output logic               halted,
    output rip_pkg::reg_addr_t rs1_num,
    output rip_pkg::reg_addr_t rs2_num,
    input  rip_pkg::word_t     rs1,
    input  rip_pkg::word_t     rs2,
    output logic               wen,
    output rip_pkg::reg_addr_t rd_num,
    output rip_pkg::word_t     wdata,
    output rip_pkg::mem_req_t  req,
    input  rip_pkg::mem_rsp_t  rsp
);
    import rip_pkg::*;

    logic  active;
    logic  is_mem;
    logic  writes_rd;
    logic  branch_taken;
    word_t result;

    assign active  = inst_valid && !halted;
    assign rs1_num = inst.rs1;
    assign rs2_num = inst.rs2;

    always_comb begin
        result       = '0;
        writes_rd    = 1'b1;
        branch_taken = 1'b0;
        is_mem       = 1'b0;
        case (inst.op)
            OP_ADD:  result = rs1 + rs2;
            OP_SUB:  result = rs1 - rs2;
            OP_AND:  result = rs1 & rs2;
            OP_OR:   result = rs1 | rs2;
            OP_XOR:  result = rs1 ^ rs2;
            OP_SLT:  result = word_t'($signed(rs1) < $signed(rs2));
            OP_ADDI: result = rs1 + inst.imm;
            OP_LUI:  result = inst.imm;
            OP_LW:   is_mem = 1'b1;
            OP_SW: begin
                is_mem    = 1'b1;
                writes_rd = 1'b0;
            end
            OP_BEQ: begin
                branch_taken = (rs1 == rs2);
                writes_rd    = 1'b0;
            end
            OP_BNE: begin
                branch_taken = (rs1 != rs2);
                writes_rd    = 1'b0;
            end
            OP_JAL: begin
                // link to the next sequential instruction
                branch_taken = 1'b1;
                result       = inst_pc + INST_BYTES;
            end
            default: writes_rd = 1'b0;
        endcase
    end

    // held while waiting, since fetch keeps inst stable until take
    always_comb begin
        req.valid = active && is_mem;
        req.we    = (inst.op == OP_SW);
        req.addr  = rs1 + inst.imm;
        req.wdata = rs2;
    end

    assign take        = active && (!is_mem || rsp.ack);
    assign redirect    = take && branch_taken;
    assign redirect_pc = inst_pc + inst.imm;

    assign wen    = take && writes_rd;
    assign rd_num = inst.rd;
    assign wdata  = (inst.op == OP_LW) ? rsp.rdata : result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            halted <= 1'b0;
        end else if (take && inst.op == OP_EBREAK) begin
            halted <= 1'b1;
        end
    end

endmodule

// File: rtl/rip_fetch.sv
`timescale 1ns/1ps

module rip_fetch (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               redirect,
    input  rip_pkg::word_t     redirect_pc,
    input  logic               halted,
    input  logic               take,
    output logic               inst_valid,
    output rip_pkg::dec_inst_t inst,
    output rip_pkg::word_t     inst_pc,
    output rip_pkg::mem_req_t  req,
    input  rip_pkg::mem_rsp_t  rsp
);
    import rip_pkg::*;

    word_t     pc;
    word_t     req_pc;
    logic      req_active;
    logic      squash;
    logic      fill;
    dec_inst_t fetched;

    // presented slot and one-word prefetch slot
    logic      cur_valid;
    dec_inst_t cur_inst;
    word_t     cur_pc;
    logic      pf_valid;
    dec_inst_t pf_inst;
    word_t     pf_pc;

    rip_decode decode (
        .code(rsp.rdata),
        .inst(fetched)
    );

    assign fill = rsp.ack && !squash;

    always_comb begin
        req.valid = req_active;
        req.we    = 1'b0;
        req.addr  = req_pc;
        req.wdata = '0;
    end

    assign inst_valid = cur_valid;
    assign inst       = cur_inst;
    assign inst_pc    = cur_pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc         <= RESET_PC;
            req_active <= 1'b0;
            squash     <= 1'b0;
            cur_valid  <= 1'b0;
            pf_valid   <= 1'b0;
        end else begin
            if (req_active) begin
                if (rsp.ack) begin
                    req_active <= 1'b0;
                end
            end else if (!pf_valid && !halted && !redirect) begin
                req_active <= 1'b1;
                pc         <= pc + INST_BYTES;
            end

            if (redirect) begin
                pc        <= redirect_pc;
                cur_valid <= 1'b0;
                pf_valid  <= 1'b0;
                // word still in flight belongs to the old path
                squash    <= req_active && !rsp.ack;
            end else begin
                if (rsp.ack) begin
                    squash <= 1'b0;
                end
                if (take) begin
                    cur_valid <= pf_valid || fill;
                    pf_valid  <= 1'b0;
                end else if (fill) begin
                    if (cur_valid) begin
                        pf_valid <= 1'b1;
                    end else begin
                        cur_valid <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!req_active) begin
            req_pc <= pc;
        end
        if (take && pf_valid) begin
            cur_inst <= pf_inst;
            cur_pc   <= pf_pc;
        end else if (fill && (take || !cur_valid)) begin
            cur_inst <= fetched;
            cur_pc   <= req_pc;
        end
        if (fill && cur_valid && !take) begin
            pf_inst <= fetched;
            pf_pc   <= req_pc;
        end
    end

endmodule

// File: rtl/rip_mem_arbiter.sv
`timescale 1ns/1ps

module rip_mem_arbiter #(
    parameter int ADDR_MASK_BITS = 16
) (
    input  logic              clk,
    input  logic              rst_n,
    input  rip_pkg::word_t    head,
    input  rip_pkg::mem_req_t fetch_req,
    output rip_pkg::mem_rsp_t fetch_rsp,
    input  rip_pkg::mem_req_t exec_req,
    output rip_pkg::mem_rsp_t exec_rsp,
    output rip_pkg::mem_req_t ext_req,
    input  rip_pkg::mem_rsp_t ext_rsp,
    output logic              idle
);
    import rip_pkg::*;

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_FETCH,
        OWN_EXEC
    } owner_t;

    localparam word_t LOW_MASK = word_t'((33'd1 << ADDR_MASK_BITS) - 33'd1);

    owner_t   owner;
    owner_t   grant;
    mem_req_t sel_req;

    // a running transfer keeps the bus, execute wins a fresh tie
    always_comb begin
        if (owner != OWN_NONE) begin
            grant = owner;
        end else if (exec_req.valid) begin
            grant = OWN_EXEC;
        end else if (fetch_req.valid) begin
            grant = OWN_FETCH;
        end else begin
            grant = OWN_NONE;
        end
    end

    always_comb begin
        case (grant)
            OWN_EXEC:  sel_req = exec_req;
            OWN_FETCH: sel_req = fetch_req;
            default:   sel_req = '0;
        endcase
        ext_req      = sel_req;
        ext_req.addr = (sel_req.addr & LOW_MASK) | head;
    end

    always_comb begin
        fetch_rsp.ack   = ext_rsp.ack && (grant == OWN_FETCH);
        fetch_rsp.rdata = (grant == OWN_FETCH) ? ext_rsp.rdata : '0;
        exec_rsp.ack    = ext_rsp.ack && (grant == OWN_EXEC);
        exec_rsp.rdata  = (grant == OWN_EXEC) ? ext_rsp.rdata : '0;
    end

    assign idle = (grant == OWN_NONE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            owner <= OWN_NONE;
        end else if (ext_rsp.ack) begin
            owner <= OWN_NONE;
        end else begin
            owner <= grant;
        end
    end

endmodule

// File: rtl/rip_pkg.sv
package rip_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam word_t RESET_PC   = 32'h0000_0000;
    localparam word_t INST_BYTES = 32'd4;

    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_ADDI,
        OP_LUI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_JAL,
        OP_EBREAK
    } op_t;

    typedef struct packed {
        op_t       op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     imm;
    } dec_inst_t;

    // request is a held level, completion is a one-cycle ack
    typedef struct packed {
        logic  valid;
        logic  we;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  ack;
        word_t rdata;
    } mem_rsp_t;

    typedef enum logic [1:0] {
        CORE_IDLE,
        CORE_RUNNING,
        CORE_DRAINING
    } core_state_t;

endpackage

// File: rtl/rip_regfile.sv
`timescale 1ns/1ps

module rip_regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  rip_pkg::reg_addr_t rs1_num,
    input  rip_pkg::reg_addr_t rs2_num,
    output rip_pkg::word_t     rs1,
    output rip_pkg::word_t     rs2,
    input  logic               wen,
    input  rip_pkg::reg_addr_t rd_num,
    input  rip_pkg::word_t     wdata
);
    import rip_pkg::*;

    word_t regs [32];

    assign rs1 = regs[rs1_num];
    assign rs2 = regs[rs2_num];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd_num != '0) begin
            regs[rd_num] <= wdata;
        end
    end

endmodule

// File: sim/rip_core_asserts.sv
`timescale 1ns/1ps

module rip_core_asserts (
    input logic              clk,
    input logic              rst_n,
    input rip_pkg::mem_req_t ext_req,
    input rip_pkg::mem_rsp_t ext_rsp,
    input logic              fetch_ack,
    input logic              exec_ack,
    input logic              fetch_owns,
    input logic              exec_owns
);

    // an open transfer holds address, data and direction
    property req_held;
        @(posedge clk) disable iff (!rst_n)
            ext_req.valid && !ext_rsp.ack |=> $stable(ext_req);
    endproperty

    assert property (req_held)
        else $error("memory request changed before its ack");

    assert property (@(posedge clk) disable iff (!rst_n) fetch_ack |-> fetch_owns)
        else $error("fetch received an ack without owning the bus");

    assert property (@(posedge clk) disable iff (!rst_n) exec_ack |-> exec_owns)
        else $error("execute received an ack without owning the bus");

    assert property (@(posedge clk) !rst_n |=> !ext_req.valid)
        else $error("memory request raised right after reset");

endmodule

// File: sim/rip_core_tb.sv
`timescale 1ns/1ps

module rip_core_tb;
    import rip_pkg::*;

    localparam int    ADDR_MASK_BITS = 16;
    localparam int    TIMEOUT_CYCLES = 2000;
    localparam word_t EBREAK         = 32'h0010_0073;

    logic     clk;
    logic     rst_n;
    logic     run;
    word_t    mem_head;
    logic     busy;
    mem_req_t ext_req;
    mem_rsp_t ext_rsp;

    int       errors;
    int       checks;
    int       tests;
    word_t    prog [$];

    rip_core #(
        .ADDR_MASK_BITS(ADDR_MASK_BITS)
    ) uut (
        .clk     (clk),
        .rst_n   (rst_n),
        .run     (run),
        .mem_head(mem_head),
        .busy    (busy),
        .ext_req (ext_req),
        .ext_rsp (ext_rsp)
    );

    rip_tb_memory mem_model (
        .clk  (clk),
        .rst_n(rst_n),
        .req  (ext_req),
        .rsp  (ext_rsp)
    );

    bind rip_mem_arbiter rip_core_asserts asserts (
        .clk       (clk),
        .rst_n     (rst_n),
        .ext_req   (ext_req),
        .ext_rsp   (ext_rsp),
        .fetch_ack (fetch_rsp.ack),
        .exec_ack  (exec_rsp.ack),
        .fetch_owns(owner == OWN_FETCH),
        .exec_owns (owner == OWN_EXEC)
    );

    always #4 clk = ~clk;

    function automatic word_t encode_r(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic word_t encode_addi(int rd, int rs1, int imm);
        return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
    endfunction

    function automatic word_t encode_lui(int rd, logic [19:0] upper);
        return {upper, 5'(rd), 7'b0110111};
    endfunction

    function automatic word_t encode_lw(int rd, int rs1, int imm);
        return {12'(imm), 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
    endfunction

    function automatic word_t encode_sw(int rs2, int rs1, int imm);
        logic [11:0] i;
        i = 12'(imm);
        return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], 7'b0100011};
    endfunction

    function automatic word_t encode_branch(logic [2:0] f3, int rs1, int rs2, int off);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], 7'b1100011};
    endfunction

    function automatic word_t encode_jal(int rd, int off);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'b1101111};
    endfunction

    task automatic load_program(word_t head);
        foreach (prog[i]) begin
            mem_model.write_word(head | word_t'(i * 4), prog[i]);
        end
    endtask

    task automatic check_word(word_t addr, word_t exp, string what);
        word_t got;
        got = mem_model.read_word(addr);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %0t: %s at %h is %h, expected %h", $time, what, addr, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // level wait, sampled at the falling edge
    task automatic wait_busy(logic level, output bit ok);
        int n;
        n = 0;
        while (busy !== level && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        ok = (busy === level);
        if (!ok) begin
            $display("timeout at %0t: busy never went %s", $time, level ? "high" : "low");
            errors++;
        end
    endtask

    task automatic start_run(word_t head);
        @(posedge clk);
        mem_head <= head;
        run      <= 1'b1;
        @(posedge clk);
        run <= 1'b0;
        @(negedge clk);
    endtask

    task automatic run_program(word_t head, output bit ok);
        start_run(head);
        wait_busy(1'b1, ok);
        if (ok) begin
            wait_busy(1'b0, ok);
        end
    endtask

    task automatic finish_test(string name, int start);
        tests++;
        $display("%-16s done, %0d error(s)", name, errors - start);
    endtask

    task automatic test_run_control();
        int start;
        bit ok;
        start = errors;
        repeat (4) begin
            @(negedge clk);
            check_flag(busy, 1'b0, "busy after reset");
            check_flag(ext_req.valid, 1'b0, "memory request after reset");
        end
        mem_model.clear();
        prog.delete();
        prog.push_back(encode_addi(1, 0, 21));
        prog.push_back(encode_sw(1, 0, 'h100));
        prog.push_back(EBREAK);
        load_program('0);
        start_run('0);
        check_flag(busy, 1'b1, "busy after run");
        // second pulse with another head lands mid run
        @(posedge clk);
        mem_head <= 32'h0002_0000;
        run      <= 1'b1;
        @(posedge clk);
        run <= 1'b0;
        @(negedge clk);
        wait_busy(1'b0, ok);
        if (ok) begin
            repeat (6) begin
                @(negedge clk);
                check_flag(busy, 1'b0, "busy after a run pulsed while busy");
            end
            check_word(32'h100, 32'd21, "stored value");
        end
        finish_test("run control", start);
    endtask

    task automatic test_arith();
        int    start;
        bit    ok;
        word_t a;
        word_t b;
        word_t c;
        word_t exp [8];
        start  = errors;
        a      = 32'd100;
        b      = 32'hffff_fff9;
        c      = 32'h1234_5000;
        exp[0] = a + b;
        exp[1] = b - a;
        exp[2] = a & b;
        exp[3] = c | a;
        exp[4] = c ^ b;
        exp[5] = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
        exp[6] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        exp[7] = c;
        mem_model.clear();
        prog.delete();
        prog.push_back(encode_addi(1, 0, 100));
        prog.push_back(encode_addi(2, 0, -7));
        prog.push_back(encode_lui(3, 20'h12345));
        prog.push_back(encode_r(7'h00, 3'b000, 4, 1, 2));
        prog.push_back(encode_r(7'h20, 3'b000, 5, 2, 1));
        prog.push_back(encode_r(7'h00, 3'b111, 6, 1, 2));
        prog.push_back(encode_r(7'h00, 3'b110, 7, 3, 1));
        prog.push_back(encode_r(7'h00, 3'b100, 8, 3, 2));
        prog.push_back(encode_r(7'h00, 3'b010, 9, 2, 1));
        prog.push_back(encode_r(7'h00, 3'b010, 10, 1, 2));
        for (int i = 0; i < 7; i++) begin
            prog.push_back(encode_sw(4 + i, 0, 'h100 + 4 * i));
        end
        prog.push_back(encode_sw(3, 0, 'h11c));
        prog.push_back(EBREAK);
        load_program('0);
        run_program('0, ok);
        if (ok) begin
            for (int i = 0; i < 8; i++) begin
                check_word(word_t'(32'h100 + 4 * i), exp[i], "alu result");
            end
        end
        finish_test("arithmetic", start);
    endtask

    task automatic test_load_use();
        int    start;
        bit    ok;
        word_t data;
        start = errors;
        data  = 32'h1357_9bdf;
        mem_model.clear();
        prog.delete();
        prog.push_back(encode_addi(1, 0, 'h200));
        prog.push_back(encode_addi(3, 0, 55));
        prog.push_back(encode_lw(2, 1, 0));
        prog.push_back(encode_r(7'h00, 3'b000, 4, 2, 3));
        prog.push_back(encode_sw(4, 1, 4));
        prog.push_back(EBREAK);
        load_program('0);
        mem_model.write_word(32'h200, data);
        run_program('0, ok);
        if (ok) begin
            check_word(32'h204, data + 32'd55, "load plus addend");
        end
        finish_test("load use", start);
    endtask

    task automatic test_branches();
        int    start;
        bit    ok;
        word_t link;
        word_t exp [9];
        start = errors;
        mem_model.clear();
        prog.delete();
        prog.push_back(encode_addi(1, 0, 5));
        prog.push_back(encode_addi(2, 0, 5));
        prog.push_back(encode_addi(3, 0, 6));
        prog.push_back(encode_branch(3'b000, 1, 2, 12));
        prog.push_back(encode_sw(1, 0, 'h300));
        prog.push_back(encode_sw(1, 0, 'h304));
        prog.push_back(encode_branch(3'b001, 1, 2, 8));
        prog.push_back(encode_sw(3, 0, 'h308));
        prog.push_back(encode_branch(3'b001, 1, 3, 12));
        prog.push_back(encode_sw(1, 0, 'h30c));
        prog.push_back(encode_sw(1, 0, 'h310));
        prog.push_back(encode_branch(3'b000, 1, 3, 8));
        prog.push_back(encode_sw(2, 0, 'h314));
        link = word_t'(prog.size() * 4 + 4);
        prog.push_back(encode_jal(5, 12));
        prog.push_back(encode_sw(1, 0, 'h318));
        prog.push_back(encode_sw(1, 0, 'h31c));
        prog.push_back(encode_sw(5, 0, 'h320));
        prog.push_back(EBREAK);
        load_program('0);
        foreach (exp[i]) begin
            exp[i] = 32'hcafe_0000 | word_t'(32'h300 + 4 * i);
            mem_model.write_word(word_t'(32'h300 + 4 * i), exp[i]);
        end
        // only the fall-through and jump-target stores land
        exp[2] = 32'd6;
        exp[5] = 32'd5;
        exp[8] = link;
        run_program('0, ok);
        if (ok) begin
            foreach (exp[i]) begin
                check_word(word_t'(32'h300 + 4 * i), exp[i], "branch path word");
            end
        end
        finish_test("branches", start);
    endtask

    task automatic test_heads();
        int    start;
        bit    ok;
        int    addend;
        word_t data;
        word_t heads [2];
        start    = errors;
        heads[0] = 32'h0001_0000;
        heads[1] = 32'h0004_0000;
        mem_model.clear();
        for (int r = 0; r < 2; r++) begin
            addend = 'h70 + r;
            data   = 32'h0a0b_0c00 + word_t'(r);
            prog.delete();
            prog.push_back(encode_addi(1, 0, addend));
            prog.push_back(encode_sw(1, 0, 'h100));
            prog.push_back(encode_lw(2, 0, 'h104));
            prog.push_back(encode_r(7'h00, 3'b000, 3, 2, 1));
            prog.push_back(encode_sw(3, 0, 'h108));
            prog.push_back(EBREAK);
            load_program(heads[r]);
            mem_model.write_word(heads[r] | 32'h104, data);
            run_program(heads[r], ok);
            if (ok) begin
                check_word(heads[r] | 32'h100, word_t'(addend), "store under head");
                check_word(heads[r] | 32'h108, data + word_t'(addend), "sum under head");
            end
        end
        check_flag(mem_model.holds(32'h100), 1'b0, "store outside the head region");
        finish_test("region heads", start);
    endtask

    task automatic test_random_latency();
        int    start;
        bit    ok;
        word_t img [32];
        start = errors;
        mem_model.clear();
        prog.delete();
        foreach (img[i]) begin
            img[i] = $urandom;
            mem_model.write_word(word_t'(32'h400 + 4 * i), img[i]);
        end
        for (int i = 0; i < 8; i++) begin
            prog.push_back(encode_lw(i + 1, 0, 'h400 + 4 * i));
            prog.push_back(encode_sw(i + 1, 0, 'h440 + 4 * (7 - i)));
            img[16 + 7 - i] = img[i];
        end
        prog.push_back(encode_lw(20, 0, 'h440));
        prog.push_back(encode_addi(20, 20, 1));
        prog.push_back(encode_sw(20, 0, 'h460));
        img[24] = img[16] + 32'd1;
        prog.push_back(EBREAK);
        // past the halt, never executed
        prog.push_back(encode_sw(1, 0, 'h47c));
        load_program('0);
        run_program('0, ok);
        if (ok) begin
            foreach (img[i]) begin
                check_word(word_t'(32'h400 + 4 * i), img[i], "memory image");
            end
            check_flag(ext_req.valid, 1'b0, "memory request after the run");
        end
        finish_test("random latency", start);
    endtask

    initial begin
        void'($urandom(32'he593));
        clk      = 1'b0;
        rst_n    = 1'b0;
        run      = 1'b0;
        mem_head = '0;
        errors   = 0;
        checks   = 0;
        tests    = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        test_run_control();
        test_arith();
        test_load_use();
        test_branches();
        test_heads();
        test_random_latency();

        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: sim/rip_tb_memory.sv
`timescale 1ns/1ps

module rip_tb_memory (
    input  logic              clk,
    input  logic              rst_n,
    input  rip_pkg::mem_req_t req,
    output rip_pkg::mem_rsp_t rsp
);
    import rip_pkg::*;

    // keyed by word address
    word_t      mem [word_t];
    logic       pending;
    logic [1:0] delay;

    function automatic void clear();
        mem.delete();
    endfunction

    function automatic void write_word(word_t addr, word_t data);
        mem[addr >> 2] = data;
    endfunction

    function automatic bit holds(word_t addr);
        return mem.exists(addr >> 2);
    endfunction

    function automatic word_t read_word(word_t addr);
        if (mem.exists(addr >> 2)) begin
            return mem[addr >> 2];
        end
        // unwritten words read back a pattern of the full address
        return {addr[7:0], addr[31:8]} ^ 32'h5a3c_96e1;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
            delay   <= '0;
            rsp     <= '0;
        end else begin
            rsp.ack <= 1'b0;
            if (pending) begin
                if (delay == '0) begin
                    pending   <= 1'b0;
                    rsp.ack   <= 1'b1;
                    rsp.rdata <= read_word(req.addr);
                    if (req.we) begin
                        write_word(req.addr, req.wdata);
                    end
                end else begin
                    delay <= delay - 2'd1;
                end
            end else if (req.valid && !rsp.ack) begin
                // 1 to 4 wait cycles per transfer
                pending <= 1'b1;
                delay   <= 2'($urandom_range(3, 0));
            end
        end
    end

endmodule

// File: sources.f
rtl/rip_pkg.sv
rtl/rip_decode.sv
rtl/rip_regfile.sv
rtl/rip_fetch.sv
rtl/rip_execute.sv
rtl/rip_mem_arbiter.sv
rtl/rip_core.sv
sim/rip_tb_memory.sv
sim/rip_core_asserts.sv
sim/rip_core_tb.sv
